// File: Makefile
TOP       ?= lsu_cluster_tb
RTL_TOP   ?= lsu_cluster_top
VERILATOR ?= verilator
SEED      ?= 1
FILELIST  ?= lsu_cluster_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --x-assign unique --x-initial unique

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+rand+reset+2 +verilator+seed+$(SEED) > $(LOG) 2>&1; \
	status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG) || \
	   ! grep -q "Everything OK" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Station geometry
`define RS_DEPTH 8
`define RS_IDX_W 3

// ROB tag and data path widths
`define TAG_W 6
`define DATA_W 32

// Number of common data bus lanes
`define CDB_W 2

// Signed immediate offset of a memory op
`define OFS_W 12

// Word address width of the data memory, 16 words
`define MEM_AW 4

`endif

// File: common/lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

  typedef struct packed {
    logic                     is_load;
    logic                     is_store;
    logic signed [`OFS_W-1:0] offset;  // Added to the base operand
  } lsu_uop_t;

  // Distance of a tag from the ROB head, wrapping at the tag width
  function automatic logic [`TAG_W-1:0] rob_age(
      input logic [`TAG_W-1:0] tag,
      input logic [`TAG_W-1:0] head
  );
    logic [`TAG_W-1:0] diff;
    diff = tag - head;
    return diff;  // Smaller is older
  endfunction

endpackage

// File: lsu_cluster_top.f
+incdir+common
common/lsu_pkg.sv
lsu_rs/lsu_rs_alloc.sv
lsu_rs/lsu_rs_station.sv
lsu_rs/lsu_rs_issue_select.sv
source/lsu_mem_unit.sv
source/lsu_cluster_top.sv
tb/lsu_tb_clock.sv
tb/lsu_cluster_props.sv
tb/lsu_cluster_tb.sv

// File: lsu_rs/lsu_rs_alloc.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_rs_alloc (
  input  logic [`RS_DEPTH-1:0] busy_vector,
  input  logic                 disp_valid,
  output logic                 disp_ready,
  output logic [`RS_DEPTH-1:0] entry_wen
);

  logic [`RS_DEPTH-1:0] free_vec;
  logic [`RS_DEPTH-1:0] first_free;

  assign free_vec = ~busy_vector;

  // Priority encoder, lowest free entry wins
  always_comb begin
    logic found;
    found      = 1'b0;
    first_free = '0;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      if (free_vec[i] && !found) begin
        found         = 1'b1;
        first_free[i] = 1'b1;
      end
    end
  end

  assign disp_ready = |free_vec;  // Back-pressure when the station is full

  // A write only happens on an accepted dispatch
  always_comb begin
    if (disp_valid && disp_ready) begin
      entry_wen = first_free;
    end else begin
      entry_wen = '0;
    end
  end

endmodule

// File: lsu_rs/lsu_rs_issue_select.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_rs_issue_select
  import lsu_pkg::*;
(
  input  logic [`RS_DEPTH-1:0]        ready_mask,
  input  logic [`RS_DEPTH*`TAG_W-1:0] tags_flat,
  input  logic [`TAG_W-1:0]           rob_head,
  input  logic                        flush,
  output logic [`RS_DEPTH-1:0]        issue_grant,
  output logic [`RS_IDX_W-1:0]        sel_idx
);

  logic                found;
  logic [`TAG_W-1:0]   best_age;
  logic [`RS_IDX_W-1:0] best_idx;

  // Oldest ready entry, strict compare keeps the lower index on a tie
  always_comb begin
    logic [`TAG_W-1:0] age;
    found    = 1'b0;
    best_age = '0;
    best_idx = '0;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      age = rob_age(tags_flat[i*`TAG_W +: `TAG_W], rob_head);
      if (ready_mask[i] && (!found || age < best_age)) begin
        found    = 1'b1;
        best_age = age;
        best_idx = `RS_IDX_W'(i);
      end
    end
  end

  always_comb begin
    issue_grant = '0;
    if (found && !flush) begin
      issue_grant[best_idx] = 1'b1;  // Nothing issues in a flush cycle
    end
  end

  assign sel_idx = best_idx;

endmodule

// File: lsu_rs/lsu_rs_station.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_rs_station
  import lsu_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,
  input  logic [`TAG_W-1:0]              rob_head,
  input  logic [`RS_DEPTH-1:0]           entry_wen,

  input  lsu_uop_t                       in_op,
  input  logic [`TAG_W-1:0]              in_dst_tag,
  input  logic [`DATA_W-1:0]             in_v1,
  input  logic [`TAG_W-1:0]              in_q1,
  input  logic                           in_r1,
  input  logic [`DATA_W-1:0]             in_v2,
  input  logic [`TAG_W-1:0]              in_q2,
  input  logic                           in_r2,

  input  logic [`CDB_W-1:0]              cdb_valid,
  input  logic [`CDB_W*`TAG_W-1:0]       cdb_tag,
  input  logic [`CDB_W*`DATA_W-1:0]      cdb_value,

  input  logic [`RS_DEPTH-1:0]           issue_grant,
  input  logic [`RS_IDX_W-1:0]           sel_idx,

  output logic [`RS_DEPTH-1:0]           ready_mask,
  output logic [`RS_DEPTH-1:0]           busy_vector,
  output logic [`RS_DEPTH*`TAG_W-1:0]    tags_flat,

  output lsu_uop_t                       out_op,
  output logic [`TAG_W-1:0]              out_dst_tag,
  output logic [`DATA_W-1:0]             out_v1,
  output logic [`DATA_W-1:0]             out_v2
);

  logic [`RS_DEPTH-1:0] busy;
  lsu_uop_t             op_arr  [`RS_DEPTH];
  logic [`TAG_W-1:0]    dst_arr [`RS_DEPTH];
  logic [`DATA_W-1:0]   v1_arr  [`RS_DEPTH];
  logic [`TAG_W-1:0]    q1_arr  [`RS_DEPTH];
  logic [`RS_DEPTH-1:0] r1_arr;
  logic [`DATA_W-1:0]   v2_arr  [`RS_DEPTH];
  logic [`TAG_W-1:0]    q2_arr  [`RS_DEPTH];
  logic [`RS_DEPTH-1:0] r2_arr;

  logic [`RS_DEPTH-1:0] busy_d;
  lsu_uop_t             op_d    [`RS_DEPTH];
  logic [`TAG_W-1:0]    dst_d   [`RS_DEPTH];
  logic [`DATA_W-1:0]   v1_d    [`RS_DEPTH];
  logic [`TAG_W-1:0]    q1_d    [`RS_DEPTH];
  logic [`RS_DEPTH-1:0] r1_d;
  logic [`DATA_W-1:0]   v2_d    [`RS_DEPTH];
  logic [`TAG_W-1:0]    q2_d    [`RS_DEPTH];
  logic [`RS_DEPTH-1:0] r2_d;

  logic [`RS_DEPTH-1:0] load_block;

  // Next state: load new fields first, then snoop the CDB on the result
  always_comb begin
    busy_d = busy;
    op_d   = op_arr;
    dst_d  = dst_arr;
    v1_d   = v1_arr;
    q1_d   = q1_arr;
    r1_d   = r1_arr;
    v2_d   = v2_arr;
    q2_d   = q2_arr;
    r2_d   = r2_arr;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      if (entry_wen[i]) begin
        op_d[i]  = in_op;
        dst_d[i] = in_dst_tag;
        v1_d[i]  = in_v1;
        q1_d[i]  = in_q1;
        r1_d[i]  = in_r1;
        v2_d[i]  = in_v2;
        q2_d[i]  = in_q2;
        r2_d[i]  = in_r2;
      end
      for (int k = 0; k < `CDB_W; k++) begin
        if (cdb_valid[k]) begin
          if (!r1_d[i] && q1_d[i] == cdb_tag[k*`TAG_W +: `TAG_W]) begin
            v1_d[i] = cdb_value[k*`DATA_W +: `DATA_W];
            r1_d[i] = 1'b1;
          end
          if (!r2_d[i] && q2_d[i] == cdb_tag[k*`TAG_W +: `TAG_W]) begin
            v2_d[i] = cdb_value[k*`DATA_W +: `DATA_W];
            r2_d[i] = 1'b1;
          end
        end
      end
      if (issue_grant[i]) begin
        busy_d[i] = 1'b0;  // Grant wins over a write to the same entry
      end else if (entry_wen[i]) begin
        busy_d[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else if (flush) begin
      busy <= '0;
    end else begin
      busy <= busy_d;
    end
  end

  always_ff @(posedge clk) begin
    op_arr  <= op_d;
    dst_arr <= dst_d;
    v1_arr  <= v1_d;
    q1_arr  <= q1_d;
    r1_arr  <= r1_d;
    v2_arr  <= v2_d;
    q2_arr  <= q2_d;
    r2_arr  <= r2_d;
  end

  // A load waits while any older store is still in the station
  always_comb begin
    load_block = '0;
    for (int m = 0; m < `RS_DEPTH; m++) begin
      for (int n = 0; n < `RS_DEPTH; n++) begin
        if (busy[m] && op_arr[m].is_load && busy[n] && op_arr[n].is_store &&
            rob_age(dst_arr[n], rob_head) < rob_age(dst_arr[m], rob_head)) begin
          load_block[m] = 1'b1;
        end
      end
    end
  end

  assign ready_mask  = busy & r1_arr & r2_arr & ~load_block;
  assign busy_vector = busy;

  for (genvar g = 0; g < `RS_DEPTH; g++) begin : g_tags
    assign tags_flat[g*`TAG_W +: `TAG_W] = dst_arr[g];
  end

  assign out_op      = op_arr[sel_idx];
  assign out_dst_tag = dst_arr[sel_idx];
  assign out_v1      = v1_arr[sel_idx];
  assign out_v2      = v2_arr[sel_idx];

endmodule

// File: source/lsu_cluster_top.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_cluster_top
  import lsu_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic [`TAG_W-1:0]         rob_head,

  input  logic                      disp_valid,
  output logic                      disp_ready,
  input  lsu_uop_t                  disp_op,
  input  logic [`TAG_W-1:0]         disp_tag,
  input  logic [`DATA_W-1:0]        disp_v1,
  input  logic [`TAG_W-1:0]         disp_q1,
  input  logic                      disp_r1,
  input  logic [`DATA_W-1:0]        disp_v2,
  input  logic [`TAG_W-1:0]         disp_q2,
  input  logic                      disp_r2,

  input  logic [`CDB_W-1:0]         cdb_valid,
  input  logic [`CDB_W*`TAG_W-1:0]  cdb_tag,
  input  logic [`CDB_W*`DATA_W-1:0] cdb_value,

  output logic                      res_valid,
  output logic [`TAG_W-1:0]         res_tag,
  output logic [`DATA_W-1:0]        res_value,
  output logic                      res_is_store
);

  logic [`RS_DEPTH-1:0]        busy_vector;
  logic [`RS_DEPTH-1:0]        entry_wen;
  logic [`RS_DEPTH-1:0]        ready_mask;
  logic [`RS_DEPTH*`TAG_W-1:0] tags_flat;
  logic [`RS_DEPTH-1:0]        issue_grant;
  logic [`RS_IDX_W-1:0]        sel_idx;
  logic                        issue_valid;
  lsu_uop_t                    iss_op;
  logic [`TAG_W-1:0]           iss_tag;
  logic [`DATA_W-1:0]          iss_v1;
  logic [`DATA_W-1:0]          iss_v2;

  assign issue_valid = |issue_grant;

  lsu_rs_alloc u_alloc (
    .busy_vector (busy_vector),
    .disp_valid  (disp_valid),
    .disp_ready  (disp_ready),
    .entry_wen   (entry_wen)
  );

  lsu_rs_station u_station (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .rob_head    (rob_head),
    .entry_wen   (entry_wen),
    .in_op       (disp_op),
    .in_dst_tag  (disp_tag),
    .in_v1       (disp_v1),
    .in_q1       (disp_q1),
    .in_r1       (disp_r1),
    .in_v2       (disp_v2),
    .in_q2       (disp_q2),
    .in_r2       (disp_r2),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_value   (cdb_value),
    .issue_grant (issue_grant),
    .sel_idx     (sel_idx),
    .ready_mask  (ready_mask),
    .busy_vector (busy_vector),
    .tags_flat   (tags_flat),
    .out_op      (iss_op),
    .out_dst_tag (iss_tag),
    .out_v1      (iss_v1),
    .out_v2      (iss_v2)
  );

  lsu_rs_issue_select u_select (
    .ready_mask  (ready_mask),
    .tags_flat   (tags_flat),
    .rob_head    (rob_head),
    .flush       (flush),
    .issue_grant (issue_grant),
    .sel_idx     (sel_idx)
  );

  lsu_mem_unit u_mem_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .op           (iss_op),
    .dst_tag      (iss_tag),
    .v1           (iss_v1),
    .v2           (iss_v2),
    .res_valid    (res_valid),
    .res_tag      (res_tag),
    .res_value    (res_value),
    .res_is_store (res_is_store)
  );

endmodule

// File: source/lsu_mem_unit.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_mem_unit
  import lsu_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               issue_valid,
  input  lsu_uop_t           op,
  input  logic [`TAG_W-1:0]  dst_tag,
  input  logic [`DATA_W-1:0] v1,
  input  logic [`DATA_W-1:0] v2,
  output logic               res_valid,
  output logic [`TAG_W-1:0]  res_tag,
  output logic [`DATA_W-1:0] res_value,
  output logic               res_is_store
);

  localparam int MEM_WORDS = 1 << `MEM_AW;

  logic [`DATA_W-1:0] mem [MEM_WORDS];
  logic [`DATA_W-1:0] ofs_ext;
  logic [`MEM_AW-1:0] addr;
  logic [`DATA_W-1:0] rd_data;
  logic               wr_en;

  assign ofs_ext = `DATA_W'(op.offset);  // Sign extension
  assign addr    = v1[`MEM_AW-1:0] + ofs_ext[`MEM_AW-1:0];
  assign rd_data = mem[addr];
  assign wr_en   = issue_valid && op.is_store;

  // Word memory comes out of reset cleared
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[addr] <= v2;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      res_tag      <= dst_tag;
      res_is_store <= op.is_store;
      res_value    <= op.is_load ? rd_data : '0;  // Stores broadcast zero
    end
  end

endmodule

// File: tb/lsu_cluster_props.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_cluster_props (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 flush,
  input logic                 disp_ready,
  input logic [`RS_DEPTH-1:0] busy_vector,
  input logic [`RS_DEPTH-1:0] issue_grant,
  input logic                 res_valid
);

  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(issue_grant))
    else $error("issue_grant has more than one bit set");

  result_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
    |issue_grant |=> res_valid)
    else $error("A grant was not followed by res_valid");

  result_needs_grant: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> $past(|issue_grant))
    else $error("res_valid rose without a grant in the cycle before");

  full_blocks_dispatch: assert property (@(posedge clk) disable iff (!rst_n)
    &busy_vector |-> !disp_ready)
    else $error("disp_ready is high while every entry is busy");

  no_grant_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> issue_grant == '0)
    else $error("An entry was granted during a flush");

endmodule

bind lsu_cluster_top lsu_cluster_props u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .flush       (flush),
  .disp_ready  (disp_ready),
  .busy_vector (busy_vector),
  .issue_grant (issue_grant),
  .res_valid   (res_valid)
);

// File: tb/lsu_cluster_tb.sv
`timescale 1ns/1ns
`include "lsu_consts.svh"

module lsu_cluster_tb
  import lsu_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int RUN_CYCLES = 5 + 15 + 20 + 20 + 45 + 20 + 60;  // Reset, then each test
  localparam int MARGIN     = 50;

  logic                      clk;
  logic                      rst_n;
  logic                      flush;
  logic [`TAG_W-1:0]         rob_head;
  logic                      disp_valid;
  logic                      disp_ready;
  lsu_uop_t                  disp_op;
  logic [`TAG_W-1:0]         disp_tag;
  logic [`DATA_W-1:0]        disp_v1;
  logic [`TAG_W-1:0]         disp_q1;
  logic                      disp_r1;
  logic [`DATA_W-1:0]        disp_v2;
  logic [`TAG_W-1:0]         disp_q2;
  logic                      disp_r2;
  logic [`CDB_W-1:0]         cdb_valid;
  logic [`CDB_W*`TAG_W-1:0]  cdb_tag;
  logic [`CDB_W*`DATA_W-1:0] cdb_value;
  logic                      res_valid;
  logic [`TAG_W-1:0]         res_tag;
  logic [`DATA_W-1:0]        res_value;
  logic                      res_is_store;

  logic [`DATA_W-1:0] model_mem [1 << `MEM_AW];
  logic [31:0]        lcg_state = 32'h4a414af5;
  logic [`TAG_W-1:0]  exp_tag [$];
  logic [`DATA_W-1:0] exp_val [$];
  logic               exp_st  [$];
  logic [`TAG_W-1:0]  e_tag;
  logic [`DATA_W-1:0] e_val;
  logic               e_st;
  string              test_name = "reset";
  int                 errors = 0;
  int                 errors_at_start = 0;
  int                 checks = 0;
  int                 tests_failed = 0;

  lsu_tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

  lsu_cluster_top u_lsu_cluster_top (.*);

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Memory in program order, stores come back as zero like on the result bus
  function automatic logic [`DATA_W-1:0] model_access(input logic is_store,
      input logic [`DATA_W-1:0] base, input logic signed [`OFS_W-1:0] ofs,
      input logic [`DATA_W-1:0] data);
    logic [`DATA_W-1:0] addr;
    addr = base + {{(`DATA_W - `OFS_W){ofs[`OFS_W-1]}}, ofs};
    if (is_store) begin
      model_mem[addr[`MEM_AW-1:0]] = data;
      return '0;
    end
    return model_mem[addr[`MEM_AW-1:0]];
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic expect_result(input logic [`TAG_W-1:0] tag, input logic is_load,
      input logic [`DATA_W-1:0] base, input logic signed [`OFS_W-1:0] ofs,
      input logic [`DATA_W-1:0] data);
    exp_tag.push_back(tag);
    exp_val.push_back(model_access(!is_load, base, ofs, data));
    exp_st.push_back(!is_load);
  endtask

  task automatic drive_op(input logic [`TAG_W-1:0] tag, input logic is_load,
      input logic signed [`OFS_W-1:0] ofs, input logic [`DATA_W-1:0] base,
      input logic [`TAG_W-1:0] q1, input logic r1, input logic [`DATA_W-1:0] data,
      input logic [`TAG_W-1:0] q2, input logic r2);
    disp_valid       = 1'b1;
    disp_op.is_load  = is_load;
    disp_op.is_store = !is_load;
    disp_op.offset   = ofs;
    disp_tag         = tag;
    disp_v1          = base;
    disp_q1          = q1;
    disp_r1          = r1;
    disp_v2          = data;
    disp_q2          = q2;
    disp_r2          = r2;
  endtask

  // disp_ready only moves on a clock edge, so the falling edge shows the coming transfer
  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = disp_ready;
      next_cycle();
    end
    disp_valid = 1'b0;
  endtask

  task automatic cdb_send(input int lane, input logic [`TAG_W-1:0] tag,
      input logic [`DATA_W-1:0] value);
    cdb_valid[lane]                    = 1'b1;
    cdb_tag[lane*`TAG_W +: `TAG_W]     = tag;
    cdb_value[lane*`DATA_W +: `DATA_W] = value;
  endtask

  task automatic cdb_clear();
    cdb_valid = '0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_tag.size() != 0 && n < limit) begin
      next_cycle();
      n++;
    end
    assert (exp_tag.size() == 0)
      else begin
        $display("Test %s: %0d results never arrived", test_name, exp_tag.size());
        errors++;
      end
    repeat (3) next_cycle();  // Room for a stray result to show up
  endtask

  task automatic begin_test(input string name, input logic [`TAG_W-1:0] head);
    test_name       = name;
    rob_head        = head;
    errors_at_start = errors;
  endtask

  task automatic report_test();
    if (errors == errors_at_start) begin
      $display("Test %s: passed", test_name);
    end else begin
      $display("Test %s: failed with %0d errors", test_name, errors - errors_at_start);
      tests_failed++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && res_valid) begin
      checks++;
      assert (exp_tag.size() != 0)
        else begin
          $display("Test %s: result with tag %0d arrived when none was due", test_name,
                   res_tag);
          errors++;
        end
      if (exp_tag.size() != 0) begin
        e_tag = exp_tag.pop_front();
        e_val = exp_val.pop_front();
        e_st  = exp_st.pop_front();
        assert (res_tag == e_tag && res_value == e_val && res_is_store == e_st)
          else begin
            $display("FAILED %s: expected tag %0d %08h st %0b, actual tag %0d %08h st %0b",
                     test_name, e_tag, e_val, e_st, res_tag, res_value, res_is_store);
            errors++;
          end
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (RUN_CYCLES + MARGIN));
    $display("Watchdog expired after %0d cycles while running test %s",
             RUN_CYCLES + MARGIN, test_name);
    $display("Something failed");
    $finish;
  end

  initial begin
    logic [`DATA_W-1:0]       base;
    logic [`DATA_W-1:0]       data;
    logic [31:0]              rnd;
    logic [`TAG_W-1:0]        tag;
    logic [`DATA_W-1:0]       bases [`RS_DEPTH + 1];
    rst_n      = 1'b0;
    flush      = 1'b0;
    rob_head   = '0;
    disp_valid = 1'b0;
    disp_op    = '0;
    disp_tag   = '0;
    disp_v1    = '0;
    disp_q1    = '0;
    disp_r1    = 1'b0;
    disp_v2    = '0;
    disp_q2    = '0;
    disp_r2    = 1'b0;
    cdb_valid  = '0;
    cdb_tag    = '0;
    cdb_value  = '0;
    for (int i = 0; i < (1 << `MEM_AW); i++) begin
      model_mem[i] = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();

    begin_test("store_load", 6'd0);
    base = next_rand();
    data = next_rand();
    expect_result(6'd0, 1'b0, base, 12'sd3, data);
    expect_result(6'd1, 1'b1, base, 12'sd3, '0);
    drive_op(6'd0, 1'b0, 12'sd3, base, '0, 1'b1, data, '0, 1'b1);
    wait_accept();
    drive_op(6'd1, 1'b1, 12'sd3, base, '0, 1'b1, '0, '0, 1'b1);
    wait_accept();
    wait_drain(20);
    report_test();

    begin_test("wakeup", 6'd0);
    base = next_rand();
    expect_result(6'd0, 1'b1, base, -12'sd2, '0);
    drive_op(6'd0, 1'b1, -12'sd2, '0, 6'd44, 1'b0, '0, '0, 1'b1);
    wait_accept();
    repeat (5) next_cycle();
    assert (exp_tag.size() == 1)
      else begin
        $display("Test %s: load issued before its base tag was broadcast", test_name);
        errors++;
      end
    cdb_send(1, 6'd44, base);
    next_cycle();
    cdb_clear();
    wait_drain(20);
    report_test();

    begin_test("store_order", 6'd0);
    base = next_rand();
    data = next_rand();
    expect_result(6'd0, 1'b0, base, 12'sd5, data);
    expect_result(6'd1, 1'b1, base, 12'sd5, '0);
    drive_op(6'd0, 1'b0, 12'sd5, base, '0, 1'b1, '0, 6'd45, 1'b0);
    wait_accept();
    drive_op(6'd1, 1'b1, 12'sd5, base, '0, 1'b1, '0, '0, 1'b1);
    wait_accept();
    repeat (5) next_cycle();
    assert (exp_tag.size() == 2)
      else begin
        $display("Test %s: a result appeared before the store data arrived", test_name);
        errors++;
      end
    cdb_send(0, 6'd45, data);
    next_cycle();
    cdb_clear();
    wait_drain(20);
    report_test();

    begin_test("backpressure", 6'd0);
    for (int k = 0; k <= `RS_DEPTH; k++) begin
      bases[k] = next_rand();
      expect_result(`TAG_W'(k), 1'b1, bases[k], `OFS_W'(k), '0);
    end
    for (int k = 0; k < `RS_DEPTH; k++) begin
      drive_op(`TAG_W'(k), 1'b1, `OFS_W'(k), '0, `TAG_W'(40 + k), 1'b0, '0, '0, 1'b1);
      wait_accept();
    end
    drive_op(`TAG_W'(`RS_DEPTH), 1'b1, `OFS_W'(`RS_DEPTH), '0, `TAG_W'(40 + `RS_DEPTH),
             1'b0, '0, '0, 1'b1);
    repeat (4) begin
      @(negedge clk);
      assert (!disp_ready)
        else begin
          $display("Test %s: disp_ready stayed high with a full station", test_name);
          errors++;
        end
      next_cycle();
    end
    cdb_send(0, 6'd40, bases[0]);
    next_cycle();
    cdb_clear();
    wait_accept();
    // Two lanes at a time, so several entries are ready together
    for (int k = 1; k <= `RS_DEPTH; k += 2) begin
      cdb_send(0, `TAG_W'(40 + k), bases[k]);
      cdb_send(1, `TAG_W'(41 + k), bases[k + 1]);
      next_cycle();
    end
    cdb_clear();
    wait_drain(30);
    report_test();

    begin_test("flush", 6'd0);
    for (int k = 0; k < 3; k++) begin
      drive_op(`TAG_W'(k), 1'b1, '0, '0, `TAG_W'(50 + k), 1'b0, '0, '0, 1'b1);
      wait_accept();
    end
    // A ready load sits in the station when the flush comes and must not issue
    drive_op(6'd3, 1'b1, '0, '0, '0, 1'b1, '0, '0, 1'b1);
    wait_accept();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    @(negedge clk);
    assert (disp_ready && u_lsu_cluster_top.busy_vector == '0)
      else begin
        $display("Test %s: station still holds entries after the flush", test_name);
        errors++;
      end
    next_cycle();
    cdb_send(0, 6'd50, next_rand());
    cdb_send(1, 6'd51, next_rand());
    next_cycle();
    cdb_clear();
    cdb_send(0, 6'd52, next_rand());
    next_cycle();
    cdb_clear();
    wait_drain(5);
    report_test();

    begin_test("random", 6'd60);  // Tags wrap past the top of the tag space
    for (int k = 0; k < 40; k++) begin
      rnd  = next_rand();
      base = next_rand();
      data = next_rand();
      tag  = `TAG_W'(60 + k);
      expect_result(tag, rnd[31], base, rnd[27:16], data);
      drive_op(tag, rnd[31], rnd[27:16], base, '0, 1'b1, data, '0, 1'b1);
      wait_accept();
    end
    wait_drain(40);
    report_test();

    $display("Tests run: 6, failed: %0d, results checked: %0d, errors: %0d",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: tb/lsu_tb_clock.sv
`timescale 1ns/1ns

module lsu_tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

endmodule
